// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP      = branchUnitTb
FILELIST = all.f

.PHONY: simulate clean

# build, run, then look for the pass line in the output
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: all.f
rtl/bpConfigPkg.sv
rtl/bpKindPkg.sv
rtl/instFact.sv
rtl/pastLog.sv
rtl/returnStack.sv
rtl/predictUnit.sv
rtl/branchUnit.sv
verification/clockGen.sv
verification/branchUnitTb.sv

// File: rtl/bpConfigPkg.sv
// bpConfigPkg: address, table and return stack sizing for the branch predictor
package bpConfigPkg;

    //////////////////////////////////////////////////
    // addresses
    //////////////////////////////////////////////////

    localparam int addrWidth = 32;          // full pc
    localparam int pairBytes = 8;           // two 32-bit slots per fetch pair

    //////////////////////////////////////////////////
    // table indexing
    //////////////////////////////////////////////////

    // index sits right above the pair offset, pc[7:3]
    localparam int indexWidth = 5;          // 32 entries

    // everything above the index is kept as tag, pc[31:8]
    localparam int tagWidth = 24;

    //////////////////////////////////////////////////
    // return stack
    //////////////////////////////////////////////////

    localparam int stackDepth    = 8;
    localparam int stackPtrWidth = 3;       // log2 of stackDepth

endpackage

// File: rtl/bpKindPkg.sv
// bpKindPkg: slot kind encodings and two-bit counter constants for the predictor
package bpKindPkg;

    // slot kinds as recorded by decode
    localparam int kindWidth = 2;

    localparam logic [kindWidth-1:0] kindNone   = 2'd0;   // no control flow
    localparam logic [kindWidth-1:0] kindCond   = 2'd1;   // conditional branch
    localparam logic [kindWidth-1:0] kindJump   = 2'd2;   // jump, also calls
    localparam logic [kindWidth-1:0] kindReturn = 2'd3;   // target from stack

    // saturating direction counters
    localparam int ctrWidth = 2;

    localparam logic [ctrWidth-1:0] ctrInit     = 2'd1;   // weakly not taken
    localparam logic [ctrWidth-1:0] ctrTakenMin = 2'd2;   // weakly taken and up

endpackage

// File: rtl/branchUnit.sv
// branchUnit: branch predictor top, joining fact table, counter table, stack and predictor
`timescale 1ns/10ps

module branchUnit (
    input  logic                                clk,
    input  logic                                arstN,
    // decode
    input  logic                                idVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   idPC,
    input  logic [bpKindPkg::kindWidth-1:0]     idKindLower,
    input  logic [bpKindPkg::kindWidth-1:0]     idKindUpper,
    input  logic [bpConfigPkg::addrWidth-1:0]   idTargetLower,
    input  logic [bpConfigPkg::addrWidth-1:0]   idTargetUpper,
    // execute
    input  logic                                exVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   exPC,
    input  logic [bpKindPkg::kindWidth-1:0]     exKind,
    input  logic                                exBranch,
    input  logic                                exWrong,
    // call
    input  logic                                push,
    input  logic [bpConfigPkg::addrWidth-1:0]   stackPc,
    // fetch
    input  logic                                ifVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   ifPC,
    output logic                                pdVld,
    output logic [bpConfigPkg::addrWidth-1:0]   pdPc,
    output logic                                pdBranch,
    output logic                                pdReason,
    output logic                                pdKnownLower,
    output logic                                pdKnownUpper,
    output logic [bpKindPkg::kindWidth-1:0]     pdKindLower,
    output logic [bpKindPkg::kindWidth-1:0]     pdKindUpper
);

    logic                              exHit, ifHit, trainVld, pop, notEmpty;
    logic [bpKindPkg::kindWidth-1:0]   ifKindLower, ifKindUpper;
    logic [bpConfigPkg::addrWidth-1:0] ifTargetLower, ifTargetUpper, topPc;
    logic [bpKindPkg::ctrWidth-1:0]    ifCtrLower, ifCtrUpper;

    // train only conditionals whose pair is still in the table
    assign trainVld = exVld && (exKind == bpKindPkg::kindCond) && exHit;

    instFact fact0 (
        .clk(clk), .arstN(arstN),
        .idVld(idVld), .idPC(idPC),
        .idKindLower(idKindLower), .idKindUpper(idKindUpper),
        .idTargetLower(idTargetLower), .idTargetUpper(idTargetUpper),
        .exPC(exPC), .exHit(exHit),
        .ifPC(ifPC), .ifHit(ifHit),
        .ifKindLower(ifKindLower), .ifKindUpper(ifKindUpper),
        .ifTargetLower(ifTargetLower), .ifTargetUpper(ifTargetUpper)
    );

    pastLog past0 (
        .clk(clk), .arstN(arstN),
        .eraseVld(idVld), .erasePC(idPC),           // decode resets the pair's counters
        .trainVld(trainVld), .trainPC(exPC), .trainBranch(exBranch),
        .ifPC(ifPC), .ifCtrLower(ifCtrLower), .ifCtrUpper(ifCtrUpper)
    );

    returnStack stack0 (
        .clk(clk), .arstN(arstN),
        .push(push), .pushPc(stackPc), .pop(pop), .flush(exVld && exWrong),
        .topPc(topPc), .notEmpty(notEmpty)
    );

    predictUnit predict0 (
        .clk(clk), .arstN(arstN),
        .ifVld(ifVld), .ifPC(ifPC), .ifHit(ifHit),
        .ifKindLower(ifKindLower), .ifKindUpper(ifKindUpper),
        .ifTargetLower(ifTargetLower), .ifTargetUpper(ifTargetUpper),
        .ifCtrLower(ifCtrLower), .ifCtrUpper(ifCtrUpper),
        .topPc(topPc), .notEmpty(notEmpty), .pop(pop),
        .pdVld(pdVld), .pdPc(pdPc), .pdBranch(pdBranch), .pdReason(pdReason),
        .pdKnownLower(pdKnownLower), .pdKnownUpper(pdKnownUpper),
        .pdKindLower(pdKindLower), .pdKindUpper(pdKindUpper)
    );

endmodule

// File: rtl/instFact.sv
// instFact: direct-mapped tagged table of slot kinds and targets per instruction pair
`timescale 1ns/10ps

module instFact (
    input  logic                                clk,
    input  logic                                arstN,
    // decode write port
    input  logic                                idVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   idPC,
    input  logic [bpKindPkg::kindWidth-1:0]     idKindLower,
    input  logic [bpKindPkg::kindWidth-1:0]     idKindUpper,
    input  logic [bpConfigPkg::addrWidth-1:0]   idTargetLower,
    input  logic [bpConfigPkg::addrWidth-1:0]   idTargetUpper,
    // execute lookup
    input  logic [bpConfigPkg::addrWidth-1:0]   exPC,
    output logic                                exHit,
    // fetch lookup
    input  logic [bpConfigPkg::addrWidth-1:0]   ifPC,
    output logic                                ifHit,
    output logic [bpKindPkg::kindWidth-1:0]     ifKindLower,
    output logic [bpKindPkg::kindWidth-1:0]     ifKindUpper,
    output logic [bpConfigPkg::addrWidth-1:0]   ifTargetLower,
    output logic [bpConfigPkg::addrWidth-1:0]   ifTargetUpper
);

    // storage, only valid bits are control state
    logic [2**bpConfigPkg::indexWidth-1:0] valid;
    logic [bpConfigPkg::tagWidth-1:0]      tagMem         [2**bpConfigPkg::indexWidth];
    logic [bpKindPkg::kindWidth-1:0]       kindLowerMem   [2**bpConfigPkg::indexWidth];
    logic [bpKindPkg::kindWidth-1:0]       kindUpperMem   [2**bpConfigPkg::indexWidth];
    logic [bpConfigPkg::addrWidth-1:0]     targetLowerMem [2**bpConfigPkg::indexWidth];
    logic [bpConfigPkg::addrWidth-1:0]     targetUpperMem [2**bpConfigPkg::indexWidth];

    //////////////////////////////////////////////////
    // pc slicing
    //////////////////////////////////////////////////

    logic [bpConfigPkg::indexWidth-1:0] idIndex, exIndex, ifIndex;
    logic [bpConfigPkg::tagWidth-1:0]   idTag, exTag, ifTag;

    assign idIndex = idPC[bpConfigPkg::indexWidth+2:3];   // pc[7:3]
    assign exIndex = exPC[bpConfigPkg::indexWidth+2:3];
    assign ifIndex = ifPC[bpConfigPkg::indexWidth+2:3];
    assign idTag   = idPC[bpConfigPkg::addrWidth-1:bpConfigPkg::indexWidth+3];   // pc[31:8]
    assign exTag   = exPC[bpConfigPkg::addrWidth-1:bpConfigPkg::indexWidth+3];
    assign ifTag   = ifPC[bpConfigPkg::addrWidth-1:bpConfigPkg::indexWidth+3];

    //////////////////////////////////////////////////
    // decode write
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;                        // every entry invalid
        end else if (idVld) begin
            valid[idIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (idVld) begin                        // whole entry replaced, old tag evicted
            tagMem[idIndex]         <= idTag;
            kindLowerMem[idIndex]   <= idKindLower;
            kindUpperMem[idIndex]   <= idKindUpper;
            targetLowerMem[idIndex] <= idTargetLower;
            targetUpperMem[idIndex] <= idTargetUpper;
        end
    end

    //////////////////////////////////////////////////
    // lookups
    //////////////////////////////////////////////////

    // combinational, so a write in the same edge is seen only afterwards
    assign exHit = valid[exIndex] && (tagMem[exIndex] == exTag);
    assign ifHit = valid[ifIndex] && (tagMem[ifIndex] == ifTag);

    assign ifKindLower   = kindLowerMem[ifIndex];
    assign ifKindUpper   = kindUpperMem[ifIndex];
    assign ifTargetLower = targetLowerMem[ifIndex];
    assign ifTargetUpper = targetUpperMem[ifIndex];

    // a decode with an unknown pc would poison valid bits for good
    idPcKnown: assert property (@(posedge clk) disable iff (!arstN)
        idVld |-> !$isunknown(idPC));

endmodule

// File: rtl/pastLog.sv
// pastLog: two-bit saturating direction counters per slot, erased by decode, trained by execute
`timescale 1ns/10ps

module pastLog (
    input  logic                                clk,
    input  logic                                arstN,
    // erase from decode
    input  logic                                eraseVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   erasePC,
    // training from execute
    input  logic                                trainVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   trainPC,
    input  logic                                trainBranch,
    // fetch read
    input  logic [bpConfigPkg::addrWidth-1:0]   ifPC,
    output logic [bpKindPkg::ctrWidth-1:0]      ifCtrLower,
    output logic [bpKindPkg::ctrWidth-1:0]      ifCtrUpper
);

    logic [bpKindPkg::ctrWidth-1:0] ctrLowerMem [2**bpConfigPkg::indexWidth];
    logic [bpKindPkg::ctrWidth-1:0] ctrUpperMem [2**bpConfigPkg::indexWidth];

    logic [bpConfigPkg::indexWidth-1:0] eraseIndex, trainIndex, ifIndex;
    logic                               trainUpper;   // pc bit 2 picks the slot
    logic                               trainHold;    // erase on same index wins
    logic [bpKindPkg::ctrWidth-1:0]     trainOld, trainNew;

    assign eraseIndex = erasePC[bpConfigPkg::indexWidth+2:3];
    assign trainIndex = trainPC[bpConfigPkg::indexWidth+2:3];
    assign ifIndex    = ifPC[bpConfigPkg::indexWidth+2:3];
    assign trainUpper = trainPC[2];
    assign trainHold  = eraseVld && (eraseIndex == trainIndex);

    //////////////////////////////////////////////////
    // counter step
    //////////////////////////////////////////////////

    assign trainOld = trainUpper ? ctrUpperMem[trainIndex] : ctrLowerMem[trainIndex];

    always_comb begin
        trainNew = trainOld;
        if (trainBranch && trainOld != '1) begin
            trainNew = trainOld + 1'b1;         // toward strongly taken
        end else if (!trainBranch && trainOld != '0) begin
            trainNew = trainOld - 1'b1;         // toward strongly not taken
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**bpConfigPkg::indexWidth; i++) begin
                ctrLowerMem[i] <= bpKindPkg::ctrInit;
                ctrUpperMem[i] <= bpKindPkg::ctrInit;
            end
        end else begin
            if (trainVld && !trainHold) begin
                if (trainUpper) begin
                    ctrUpperMem[trainIndex] <= trainNew;
                end else begin
                    ctrLowerMem[trainIndex] <= trainNew;
                end
            end
            if (eraseVld) begin                 // new pair decoded, forget old history
                ctrLowerMem[eraseIndex] <= bpKindPkg::ctrInit;
                ctrUpperMem[eraseIndex] <= bpKindPkg::ctrInit;
            end
        end
    end

    // read side, pre-edge values
    assign ifCtrLower = ctrLowerMem[ifIndex];
    assign ifCtrUpper = ctrUpperMem[ifIndex];

endmodule

// File: rtl/predictUnit.sv
// predictUnit: picks the taken slot, direction and next fetch pc, registered one cycle
`timescale 1ns/10ps

module predictUnit (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                ifVld,
    input  logic [bpConfigPkg::addrWidth-1:0]   ifPC,
    // table answers
    input  logic                                ifHit,
    input  logic [bpKindPkg::kindWidth-1:0]     ifKindLower,
    input  logic [bpKindPkg::kindWidth-1:0]     ifKindUpper,
    input  logic [bpConfigPkg::addrWidth-1:0]   ifTargetLower,
    input  logic [bpConfigPkg::addrWidth-1:0]   ifTargetUpper,
    input  logic [bpKindPkg::ctrWidth-1:0]      ifCtrLower,
    input  logic [bpKindPkg::ctrWidth-1:0]      ifCtrUpper,
    // return stack
    input  logic [bpConfigPkg::addrWidth-1:0]   topPc,
    input  logic                                notEmpty,
    output logic                                pop,
    // prediction, one cycle after ifVld
    output logic                                pdVld,
    output logic [bpConfigPkg::addrWidth-1:0]   pdPc,
    output logic                                pdBranch,
    output logic                                pdReason,   // 0 lower, 1 upper
    output logic                                pdKnownLower,
    output logic                                pdKnownUpper,
    output logic [bpKindPkg::kindWidth-1:0]     pdKindLower,
    output logic [bpKindPkg::kindWidth-1:0]     pdKindUpper
);

    logic knownLower, knownUpper;
    logic takenLower, takenUpper;
    logic [bpConfigPkg::addrWidth-1:0] pcLower, pcUpper, fallPc;

    // lower slot skipped when fetch enters at base + 4
    assign knownLower = ifHit && !ifPC[2] && (ifKindLower != bpKindPkg::kindNone);
    assign knownUpper = ifHit && (ifKindUpper != bpKindPkg::kindNone);

    assign takenLower = knownLower && ((ifKindLower == bpKindPkg::kindJump)
        || (ifKindLower == bpKindPkg::kindCond && ifCtrLower >= bpKindPkg::ctrTakenMin)
        || (ifKindLower == bpKindPkg::kindReturn && notEmpty));
    assign takenUpper = knownUpper && ((ifKindUpper == bpKindPkg::kindJump)
        || (ifKindUpper == bpKindPkg::kindCond && ifCtrUpper >= bpKindPkg::ctrTakenMin)
        || (ifKindUpper == bpKindPkg::kindReturn && notEmpty));

    // returns take the stack top instead of the stored target
    assign pcLower = (ifKindLower == bpKindPkg::kindReturn) ? topPc : ifTargetLower;
    assign pcUpper = (ifKindUpper == bpKindPkg::kindReturn) ? topPc : ifTargetUpper;
    assign fallPc  = {ifPC[bpConfigPkg::addrWidth-1:3], 3'b000}
                   + bpConfigPkg::addrWidth'(bpConfigPkg::pairBytes);

    // only the winning slot may consume a stack entry
    assign pop = ifVld && (takenLower ? (ifKindLower == bpKindPkg::kindReturn)
                                      : (takenUpper && ifKindUpper == bpKindPkg::kindReturn));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pdVld    <= 1'b0;
            pdBranch <= 1'b0;
            pdReason <= 1'b0;
        end else begin
            pdVld <= ifVld;
            if (ifVld) begin
                pdBranch <= takenLower || takenUpper;
                pdReason <= !takenLower && takenUpper;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ifVld) begin                        // held between requests
            pdPc         <= takenLower ? pcLower : (takenUpper ? pcUpper : fallPc);
            pdKnownLower <= knownLower;
            pdKnownUpper <= knownUpper;
            pdKindLower  <= knownLower ? ifKindLower : bpKindPkg::kindNone;
            pdKindUpper  <= knownUpper ? ifKindUpper : bpKindPkg::kindNone;
        end
    end

    reasonWithBranch: assert property (@(posedge clk) disable iff (!arstN)
        pdReason |-> pdBranch);

endmodule

// File: rtl/returnStack.sv
// returnStack: circular return address stack with push, pop and flush
`timescale 1ns/10ps

module returnStack (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                push,
    input  logic [bpConfigPkg::addrWidth-1:0]   pushPc,
    input  logic                                pop,
    input  logic                                flush,     // misprediction, drop all
    output logic [bpConfigPkg::addrWidth-1:0]   topPc,
    output logic                                notEmpty
);

    logic [bpConfigPkg::addrWidth-1:0]     stackMem [bpConfigPkg::stackDepth];
    logic [bpConfigPkg::stackPtrWidth-1:0] ptr;       // next free slot
    logic [bpConfigPkg::stackPtrWidth-1:0] topPtr;
    logic [bpConfigPkg::stackPtrWidth:0]   count;     // capped at stackDepth

    assign topPtr   = ptr - 1'b1;                     // wraps with the buffer
    assign topPc    = stackMem[topPtr];
    assign notEmpty = (count != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ptr   <= '0;
            count <= '0;
        end else if (flush) begin
            count <= '0;                              // pointer may stay anywhere
        end else if (push && !pop) begin
            ptr <= ptr + 1'b1;                        // full stack loses its oldest
            if (count != (bpConfigPkg::stackPtrWidth+1)'(bpConfigPkg::stackDepth)) begin
                count <= count + 1'b1;
            end
        end else if (pop && !push) begin
            ptr   <= topPtr;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush && push) begin
            // push with pop overwrites the current top in place
            stackMem[pop ? topPtr : ptr] <= pushPc;
        end
    end

    popNeedsEntry: assert property (@(posedge clk) disable iff (!arstN)
        pop |-> notEmpty);

endmodule

// File: verification/branchUnitTb.sv
// branchUnitTb: drives decode, execute, call and fetch traffic and checks every prediction
`timescale 1ns/10ps

module branchUnitTb;

    typedef struct packed {
        logic        vld;
        logic        popIt;                     // model bookkeeping, not a DUT output
        logic [31:0] reqPc;
        logic [31:0] pc;
        logic        branch;
        logic        reason;
        logic        knownLower;
        logic        knownUpper;
        logic [1:0]  kindLower;
        logic [1:0]  kindUpper;
    } pairPrediction;

    // run length in cycles for the watchdog
    int directedCycles = 100;
    int randomCycles   = 300;
    int marginCycles   = 50;

    logic clk, arstN;
    logic idVld, exVld, exBranch, exWrong, push, ifVld;
    logic [bpConfigPkg::addrWidth-1:0] idPC, idTargetLower, idTargetUpper, exPC, stackPc, ifPC;
    logic [bpKindPkg::kindWidth-1:0]   idKindLower, idKindUpper, exKind;
    logic pdVld, pdBranch, pdReason, pdKnownLower, pdKnownUpper;
    logic [bpConfigPkg::addrWidth-1:0] pdPc;
    logic [bpKindPkg::kindWidth-1:0]   pdKindLower, pdKindUpper;

    // shadow state updated as the DUT's next edge will update it
    logic        mValid  [2**bpConfigPkg::indexWidth];
    logic [23:0] mTag    [2**bpConfigPkg::indexWidth];
    logic [1:0]  mKind   [2**bpConfigPkg::indexWidth][2];
    logic [31:0] mTarget [2**bpConfigPkg::indexWidth][2];
    logic [1:0]  mCtr    [2**bpConfigPkg::indexWidth][2];
    logic [31:0] mStack  [$];                   // newest at the back
    pairPrediction expQ  [$];                   // one entry per driven cycle

    clockGen clkGen0 (.clk(clk), .arstN(arstN));

    branchUnit dut0 (
        .clk(clk), .arstN(arstN),
        .idVld(idVld), .idPC(idPC), .idKindLower(idKindLower), .idKindUpper(idKindUpper),
        .idTargetLower(idTargetLower), .idTargetUpper(idTargetUpper),
        .exVld(exVld), .exPC(exPC), .exKind(exKind), .exBranch(exBranch), .exWrong(exWrong),
        .push(push), .stackPc(stackPc), .ifVld(ifVld), .ifPC(ifPC),
        .pdVld(pdVld), .pdPc(pdPc), .pdBranch(pdBranch), .pdReason(pdReason),
        .pdKnownLower(pdKnownLower), .pdKnownUpper(pdKnownUpper),
        .pdKindLower(pdKindLower), .pdKindUpper(pdKindUpper)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic pairPrediction predictPair(input logic [31:0] pc);
        pairPrediction p;
        logic [4:0]  idx;
        logic        hit, known, taken;
        logic [1:0]  kind;
        logic [31:0] dest;
        p = '0;
        idx = pc[7:3];
        hit = mValid[idx] && (mTag[idx] == pc[31:8]);
        p.vld = 1'b1;
        p.reqPc = pc;
        p.pc = {pc[31:3], 3'b000} + 32'(bpConfigPkg::pairBytes);   // fall through
        for (int s = 0; s < 2; s++) begin
            kind = mKind[idx][s];
            known = hit && (kind != bpKindPkg::kindNone) && !(s == 0 && pc[2]);
            dest = mTarget[idx][s];
            if (kind == bpKindPkg::kindReturn && mStack.size() != 0) dest = mStack[$];
            case (kind)
                bpKindPkg::kindJump:   taken = known;
                bpKindPkg::kindCond:   taken = known && (mCtr[idx][s] >= bpKindPkg::ctrTakenMin);
                bpKindPkg::kindReturn: taken = known && (mStack.size() != 0);
                default:               taken = 1'b0;
            endcase
            if (s == 0) begin
                p.knownLower = known;
                p.kindLower  = known ? kind : bpKindPkg::kindNone;
            end else begin
                p.knownUpper = known;
                p.kindUpper  = known ? kind : bpKindPkg::kindNone;
            end
            if (taken && !p.branch) begin       // lower wins over upper
                p.branch = 1'b1;
                p.reason = (s == 1);
                p.pc     = dest;
                p.popIt  = (kind == bpKindPkg::kindReturn);
            end
        end
        return p;
    endfunction

    function automatic string describe(input pairPrediction p);
        return $sformatf("vld %b pc %h branch %b reason %b known %b%b kind %0d/%0d",
            p.vld, p.pc, p.branch, p.reason, p.knownLower, p.knownUpper,
            p.kindLower, p.kindUpper);
    endfunction

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////

    task automatic driveIdle();
        idVld = 1'b0;
        idPC = '0;
        idKindLower = '0;
        idKindUpper = '0;
        idTargetLower = '0;
        idTargetUpper = '0;
        exVld = 1'b0;
        exPC = '0;
        exKind = '0;
        exBranch = 1'b0;
        exWrong = 1'b0;
        push = 1'b0;
        stackPc = '0;
        ifVld = 1'b0;
        ifPC = '0;
    endtask

    task automatic decode(input logic [31:0] pc, input logic [1:0] kl, input logic [1:0] ku,
                          input logic [31:0] tl, input logic [31:0] tu);
        idVld = 1'b1;
        idPC = pc;
        idKindLower = kl;
        idKindUpper = ku;
        idTargetLower = tl;
        idTargetUpper = tu;
    endtask

    task automatic execute(input logic [31:0] pc, input logic [1:0] kind,
                           input logic taken, input logic wrong);
        exVld = 1'b1;
        exPC = pc;
        exKind = kind;
        exBranch = taken;
        exWrong = wrong;
    endtask

    task automatic pushCall(input logic [31:0] ret);
        push = 1'b1;
        stackPc = ret;
    endtask

    task automatic fetch(input logic [31:0] pc);
        ifVld = 1'b1;
        ifPC = pc;
    endtask

    // record what the coming edge must produce, mirror it, then move on
    task automatic tick();
        pairPrediction e;
        logic [4:0] exIdx, idIdx;
        logic       trainNow;
        e = '0;
        exIdx = exPC[7:3];
        idIdx = idPC[7:3];
        trainNow = exVld && (exKind == bpKindPkg::kindCond) && mValid[exIdx]
            && (mTag[exIdx] == exPC[31:8]) && !(idVld && idIdx == exIdx);   // erase wins
        if (ifVld) e = predictPair(ifPC);
        expQ.push_back(e);
        if (trainNow) begin
            if (exBranch && mCtr[exIdx][exPC[2]] != 2'd3) begin
                mCtr[exIdx][exPC[2]] = mCtr[exIdx][exPC[2]] + 2'd1;
            end else if (!exBranch && mCtr[exIdx][exPC[2]] != 2'd0) begin
                mCtr[exIdx][exPC[2]] = mCtr[exIdx][exPC[2]] - 2'd1;
            end
        end
        if (idVld) begin
            mValid[idIdx] = 1'b1;
            mTag[idIdx] = idPC[31:8];
            mKind[idIdx][0] = idKindLower;
            mKind[idIdx][1] = idKindUpper;
            mTarget[idIdx][0] = idTargetLower;
            mTarget[idIdx][1] = idTargetUpper;
            mCtr[idIdx][0] = bpKindPkg::ctrInit;
            mCtr[idIdx][1] = bpKindPkg::ctrInit;
        end
        if (exVld && exWrong) begin
            mStack.delete();                    // flush beats push and pop
        end else if (push) begin
            if (e.popIt || mStack.size() == bpConfigPkg::stackDepth) begin
                if (e.popIt) void'(mStack.pop_back());
                else void'(mStack.pop_front());  // oldest falls off
            end
            mStack.push_back(stackPc);
        end else if (e.popIt) begin
            void'(mStack.pop_back());
        end
        @(posedge clk);
        #1;
        driveIdle();
    endtask

    function automatic logic [31:0] randomPc();
        logic [23:0] tag;
        logic [4:0]  idx;
        tag = 24'h000010 + 24'($urandom % 2);  // two tags share four indices
        idx = 5'($urandom % 4);
        return {tag, idx, 1'($urandom), 2'b00};
    endfunction

    //////////////////////////////////////////////////
    // compare and watchdog
    //////////////////////////////////////////////////

    initial begin
        pairPrediction e;
        pairPrediction got;
        forever begin
            @(negedge clk);
            if (expQ.size() >= 2) begin         // front entry was sampled last edge
                e = expQ.pop_front();
                got = e;
                got.vld = pdVld;
                got.pc = pdPc;
                got.branch = pdBranch;
                got.reason = pdReason;
                got.knownLower = pdKnownLower;
                got.knownUpper = pdKnownUpper;
                got.kindLower = pdKindLower;
                got.kindUpper = pdKindUpper;
                assert (got.vld == e.vld && (!e.vld || got == e)) else begin
                    $display("Error at %0t ns: fetch of %h gave %s, expected %s",
                        $time, e.reqPc, describe(got), describe(e));
                    $display("Test FAILED");
                    $fatal(1, "prediction mismatch");
                end
            end
        end
    end

    initial begin
        #((16 + directedCycles + randomCycles + marginCycles) * 8);
        $display("Watchdog expired, the run hung before all traffic was checked");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h13b4_eda0));
        driveIdle();
        for (int i = 0; i < 2**bpConfigPkg::indexWidth; i++) begin
            mValid[i] = 1'b0;
            mCtr[i][0] = bpKindPkg::ctrInit;
            mCtr[i][1] = bpKindPkg::ctrInit;
        end
        @(posedge arstN);
        @(posedge clk);
        #1;
        // cold tables miss everywhere
        repeat (2) tick();
        fetch(32'h0000_1000);
        tick();
        fetch(32'h0000_1234);
        tick();
        // jumps with the lower slot hidden by pc bit 2 and a same-edge decode not yet visible
        decode(32'h0000_2010, bpKindPkg::kindNone, bpKindPkg::kindJump, 0, 32'h0000_3000);
        tick();
        fetch(32'h0000_2010);
        tick();
        fetch(32'h0000_2014);
        tick();
        decode(32'h0000_2020, bpKindPkg::kindJump, bpKindPkg::kindNone, 32'h0000_4000, 0);
        tick();
        fetch(32'h0000_2020);
        tick();
        fetch(32'h0000_2024);
        tick();
        decode(32'h0000_2030, bpKindPkg::kindJump, bpKindPkg::kindJump, 32'h44, 32'h88);
        fetch(32'h0000_2030);
        tick();
        fetch(32'h0000_2030);
        tick();
        // conditional training, saturation and erase by a new decode
        decode(32'h0000_4008, bpKindPkg::kindCond, bpKindPkg::kindCond, 32'h4100, 32'h4200);
        tick();
        fetch(32'h0000_4008);
        tick();
        repeat (5) begin
            execute(32'h0000_400c, bpKindPkg::kindCond, 1'b1, 1'b0);
            fetch(32'h0000_4008);
            tick();
        end
        repeat (3) begin
            execute(32'h0000_400c, bpKindPkg::kindCond, 1'b0, 1'b0);
            fetch(32'h0000_4008);
            tick();
        end
        repeat (2) begin
            execute(32'h0000_4008, bpKindPkg::kindCond, 1'b1, 1'b0);
            tick();
        end
        execute(32'h0000_400c, bpKindPkg::kindCond, 1'b1, 1'b0);
        decode(32'h0000_4008, bpKindPkg::kindCond, bpKindPkg::kindCond, 32'h4100, 32'h4200);
        tick();
        fetch(32'h0000_4008);
        tick();
        // aliasing pair with another tag
        decode(32'h0000_5008, bpKindPkg::kindCond, bpKindPkg::kindJump, 32'h5100, 32'h5200);
        tick();
        fetch(32'h0000_6008);
        tick();
        repeat (3) begin
            execute(32'h0000_6008, bpKindPkg::kindCond, 1'b1, 1'b0);
            tick();
        end
        fetch(32'h0000_5008);
        tick();
        // return stack order, push with pop, flush and overflow
        decode(32'h0000_7000, bpKindPkg::kindReturn, bpKindPkg::kindNone, 0, 0);
        tick();
        pushCall(32'h0000_0100);
        tick();
        pushCall(32'h0000_0200);
        tick();
        repeat (3) begin
            fetch(32'h0000_7000);
            tick();
        end
        pushCall(32'h0000_0300);
        tick();
        pushCall(32'h0000_0400);
        fetch(32'h0000_7000);
        tick();
        repeat (2) begin
            fetch(32'h0000_7000);
            tick();
        end
        pushCall(32'h0000_0500);
        tick();
        pushCall(32'h0000_0600);
        tick();
        execute(32'h0000_7000, bpKindPkg::kindJump, 1'b0, 1'b1);
        tick();
        fetch(32'h0000_7000);
        tick();
        for (int n = 0; n < 10; n++) begin
            pushCall(32'h0000_1000 + 32'(n * 4));
            tick();
        end
        repeat (9) begin
            fetch(32'h0000_7000);
            tick();
        end
        // mixed random traffic
        for (int n = 0; n < randomCycles; n++) begin
            if ($urandom % 4 == 0) begin
                decode(randomPc(), 2'($urandom), 2'($urandom), $urandom & 32'hffff_fffc,
                    $urandom & 32'hffff_fffc);
            end
            if ($urandom % 2 == 0) begin
                execute(randomPc(), ($urandom % 4 != 0) ? bpKindPkg::kindCond : 2'($urandom),
                    ($urandom % 2 == 0), ($urandom % 16 == 0));
            end
            if ($urandom % 4 == 0) pushCall($urandom & 32'hffff_fffc);
            if ($urandom % 4 != 0) fetch(randomPc());
            tick();
        end
        repeat (3) tick();                      // let the last results drain
        @(negedge clk);
        #1;
        if (expQ.size() > 1) begin
            $display("Comparison fell behind, %0d results were never checked", expQ.size() - 1);
            $display("Test FAILED");
            $fatal(1, "unchecked results");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: verification/clockGen.sv
// clockGen: testbench clock of 8 ns and an active low reset held for 16 cycles
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 arstN = 1'b1;                        // release clear of the edge
    end

endmodule
